// File: hdl/breq_pkg.sv
// Shared sizes, command and request encodings for the broadcast request path, import with ::*
package breq_pkg;

  // ==================================================
  // Sizes
  // ==================================================

  // CPU count, tied to the one-hot arbiter and the 2-bit CPU ID
  parameter int NUM_CPUS = 4;

  // Cache line address
  typedef logic [31:0] addr_t;
  // CPU number as sent with a broadcast
  typedef logic [1:0]  cpu_id_t;
  // Request ID, base in the upper bits and a per-CPU slot below
  typedef logic [6:0]  breq_id_t;
  // Request ID base, advances once per acknowledge cycle
  typedef logic [4:0]  breq_base_t;

  // ==================================================
  // Encodings
  // ==================================================

  // Main bus commands, only the two broadcast ones enter the FIFOs
  typedef enum logic [2:0] {
    MBUS_NOP         = 3'd0,
    MBUS_WR          = 3'd1,
    MBUS_RD          = 3'd2,
    MBUS_WR_BROAD    = 3'd3,
    MBUS_RD_BROAD    = 3'd4,
    MBUS_EVICT       = 3'd5,
    MBUS_EVICT_BROAD = 3'd6
  } mbus_cmd_t;

  // Request type carried with a broadcast
  typedef enum logic [1:0] {
    BREQ_NOP = 2'd0,
    BREQ_WR  = 2'd1,
    BREQ_RD  = 2'd2
  } breq_type_t;

  // One entry of a per-CPU request FIFO
  typedef struct packed {
    addr_t      addr;
    breq_type_t req_type;
    breq_id_t   id;
  } breq_t;

  // One request toward the broadcast FIFO
  typedef struct packed {
    addr_t      addr;
    breq_type_t req_type;
    cpu_id_t    cpu_id;
    breq_id_t   id;
  } broad_t;

endpackage

// File: hdl/mbus_accept.sv
// Main bus front end: decodes broadcast commands, pulses acks, tags each request with type and ID
`timescale 1ns/1ps

module mbus_accept
  import breq_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  mbus_cmd_t           mbus_cmd_i [NUM_CPUS],
  input  addr_t               mbus_addr_i [NUM_CPUS],
  input  logic [NUM_CPUS-1:0] fifo_full_i,
  output logic [NUM_CPUS-1:0] mbus_ack_o,
  output breq_t               breq_o [NUM_CPUS]
);

  // ==================================================
  // Command decode
  // ==================================================

  logic [NUM_CPUS-1:0] is_broad;
  breq_type_t          type_d [NUM_CPUS];
  breq_type_t          type_q [NUM_CPUS];
  logic [NUM_CPUS-1:0] ack_q;
  breq_base_t          base_q;

  // Broadcast write maps to WR, broadcast read to RD, all else NOP
  always_comb begin
    for (int c = 0; c < NUM_CPUS; c++) begin
      case (mbus_cmd_i[c])
        MBUS_WR_BROAD: type_d[c] = BREQ_WR;
        MBUS_RD_BROAD: type_d[c] = BREQ_RD;
        default:       type_d[c] = BREQ_NOP;
      endcase
      // Only a broadcast command yields a non-NOP type
      is_broad[c] = (type_d[c] != BREQ_NOP);
    end
  end

  // ==================================================
  // Ack and type registers
  // ==================================================

  // Ack is a single-cycle pulse, the low phase in between lets the CPU move on
  // A full FIFO keeps the command waiting on the bus
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack_q <= '0;
      for (int c = 0; c < NUM_CPUS; c++) begin
        type_q[c] <= BREQ_NOP;
      end
    end else begin
      ack_q  <= is_broad & ~fifo_full_i & ~ack_q;
      // Sampled every cycle, so it lines up with the ack
      type_q <= type_d;
    end
  end

  assign mbus_ack_o = ack_q;

  // ID base steps once per cycle with any ack, 5 bits wrap at 32
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      base_q <= '0;
    end else if (|ack_q) begin
      base_q <= base_q + 1'b1;
    end
  end

  // ==================================================
  // FIFO entries
  // ==================================================

  // Address is still held by the CPU during its ack cycle
  // Slot is reversed so CPU 3 takes slot 0 and CPU 0 takes slot 3
  always_comb begin
    for (int c = 0; c < NUM_CPUS; c++) begin
      breq_o[c].addr     = mbus_addr_i[c];
      breq_o[c].req_type = type_q[c];
      breq_o[c].id       = {base_q, 2'(NUM_CPUS - 1 - c)};
    end
  end

endmodule

// File: hdl/breq_fifo.sv
// Per-CPU request FIFO, written on ack and read by the arbiter, head shown without delay
`timescale 1ns/1ps

module breq_fifo
  import breq_pkg::*;
#(
  parameter int FIFO_DEPTH = 2
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  wr_i,
  input  breq_t breq_i,
  input  logic  rd_i,
  output breq_t breq_o,
  output logic  empty_o,
  output logic  full_o
);

  // Pointer and occupancy widths
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  breq_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Wraps at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ==================================================
  // Storage
  // ==================================================

  // Writer never writes when full
  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_ptr] <= breq_i;
    end
  end

  // Head entry straight from the array
  assign breq_o = mem[rd_ptr];

  // ==================================================
  // Pointers and occupancy
  // ==================================================

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_i) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Read and write together leave the count as is
      case ({wr_i, rd_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(FIFO_DEPTH));

endmodule

// File: hdl/breq_arbiter.sv
// Round-robin pick among the request FIFOs, forwards one request per cycle to the broadcast FIFO
`timescale 1ns/1ps

module breq_arbiter
  import breq_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NUM_CPUS-1:0] fifo_empty_i,
  input  breq_t               fifo_head_i [NUM_CPUS],
  input  logic                broad_fifo_full_i,
  output logic [NUM_CPUS-1:0] fifo_rd_o,
  output logic                broad_fifo_wr_o,
  output broad_t              broad_o
);

  logic [NUM_CPUS-1:0] prio_q;
  logic [NUM_CPUS-1:0] valid;
  logic [NUM_CPUS-1:0] sel;
  breq_t               head_sel;
  cpu_id_t             cpu_sel;

  // ==================================================
  // Priority and selection
  // ==================================================

  // One-hot priority, CPU 0 first after reset
  // Rotates on every forwarded request, whichever FIFO was served
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prio_q <= NUM_CPUS'(1);
    end else if (broad_fifo_wr_o) begin
      prio_q <= {prio_q[NUM_CPUS-2:0], prio_q[NUM_CPUS-1]};
    end
  end

  assign valid = ~fifo_empty_i;

  // Walk upward from the priority bit with wrap-around
  // First candidate that hits a non-empty FIFO becomes the one-hot select
  always_comb begin : search
    logic [NUM_CPUS-1:0] cand;
    logic                found;
    cand  = prio_q;
    found = 1'b0;
    sel   = '0;
    for (int k = 0; k < NUM_CPUS; k++) begin
      if (!found && |(cand & valid)) begin
        sel   = cand;
        found = 1'b1;
      end
      cand = {cand[NUM_CPUS-2:0], cand[NUM_CPUS-1]};
    end
  end

  // Broadcast FIFO full holds every read
  assign fifo_rd_o       = sel & {NUM_CPUS{~broad_fifo_full_i}};
  assign broad_fifo_wr_o = |fifo_rd_o;

  // ==================================================
  // One-hot mux
  // ==================================================

  // AND-OR mux, all zero when nothing is selected
  // CPU ID comes from the index of the selected FIFO
  always_comb begin
    head_sel = '0;
    cpu_sel  = '0;
    for (int c = 0; c < NUM_CPUS; c++) begin
      head_sel = breq_t'(head_sel | (fifo_head_i[c] & {$bits(breq_t){sel[c]}}));
      cpu_sel  = cpu_sel | (cpu_id_t'(c) & {$bits(cpu_id_t){sel[c]}});
    end
  end

  // Valid only while broad_fifo_wr_o is high
  always_comb begin
    broad_o.addr     = head_sel.addr;
    broad_o.req_type = head_sel.req_type;
    broad_o.cpu_id   = cpu_sel;
    broad_o.id       = head_sel.id;
  end

endmodule

// File: hdl/breq_fifos_top.sv
// Broadcast request front end top: acceptor, four request FIFOs and the round-robin arbiter
`timescale 1ns/1ps

module breq_fifos_top
  import breq_pkg::*;
#(
  parameter int FIFO_DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  mbus_cmd_t           mbus_cmd_i [NUM_CPUS],
  input  addr_t               mbus_addr_i [NUM_CPUS],
  input  logic                broad_fifo_full_i,
  output logic [NUM_CPUS-1:0] mbus_ack_o,
  output logic                broad_fifo_wr_o,
  output broad_t              broad_o
);

  // ==================================================
  // Internal wiring
  // ==================================================

  // Acceptor to FIFOs
  breq_t               fifo_in [NUM_CPUS];
  logic [NUM_CPUS-1:0] fifo_full;

  // FIFOs to arbiter
  breq_t               fifo_head [NUM_CPUS];
  logic [NUM_CPUS-1:0] fifo_empty;
  logic [NUM_CPUS-1:0] fifo_rd;

  // Command decode, acks and request tagging
  mbus_accept u_accept (
    .clk         (clk),
    .rst         (rst),
    .mbus_cmd_i  (mbus_cmd_i),
    .mbus_addr_i (mbus_addr_i),
    .fifo_full_i (fifo_full),
    .mbus_ack_o  (mbus_ack_o),
    .breq_o      (fifo_in)
  );

  // ==================================================
  // Request FIFOs
  // ==================================================

  // The ack pulse doubles as the FIFO write strobe
  for (genvar c = 0; c < NUM_CPUS; c++) begin : g_fifo
    breq_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .clk     (clk),
      .rst     (rst),
      .wr_i    (mbus_ack_o[c]),
      .breq_i  (fifo_in[c]),
      .rd_i    (fifo_rd[c]),
      .breq_o  (fifo_head[c]),
      .empty_o (fifo_empty[c]),
      .full_o  (fifo_full[c])
    );
  end

  // Round-robin forward toward the broadcast FIFO
  breq_arbiter u_arbiter (
    .clk               (clk),
    .rst               (rst),
    .fifo_empty_i      (fifo_empty),
    .fifo_head_i       (fifo_head),
    .broad_fifo_full_i (broad_fifo_full_i),
    .fifo_rd_o         (fifo_rd),
    .broad_fifo_wr_o   (broad_fifo_wr_o),
    .broad_o           (broad_o)
  );

endmodule

// File: bench/breq_checker.sv
// Cycle model of the broadcast request front end that watches the DUT ports and counts mismatches
`timescale 1ns/1ps

module breq_checker
  import breq_pkg::*;
#(
  parameter int FIFO_DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [127:0]        test_name_i,
  input  mbus_cmd_t           mbus_cmd_i [NUM_CPUS],
  input  addr_t               mbus_addr_i [NUM_CPUS],
  input  logic                broad_fifo_full_i,
  input  logic [NUM_CPUS-1:0] mbus_ack_i,
  input  logic                broad_fifo_wr_i,
  input  broad_t              broad_i,
  output int                  errors_o,
  output int                  pending_o,
  output int                  broad_cnt_o
);

  // ==================================================
  // Model state
  // ==================================================

  logic [NUM_CPUS-1:0] ack_m;
  breq_type_t          type_m [NUM_CPUS];
  breq_base_t          base_m;
  // Index of the CPU holding priority
  int                  prio_m;
  // Request FIFOs as shift queues with the head at entry 0
  breq_t               fifo_m [NUM_CPUS][FIFO_DEPTH];
  int                  cnt_m [NUM_CPUS];
  int                  err_cnt = 0;
  // Acks and broadcasts as seen on the DUT ports
  int                  ack_cnt = 0;
  int                  bcast_cnt = 0;
  // DUT acks not yet matched by a DUT broadcast
  int                  pending_cnt = 0;

  assign errors_o    = err_cnt;
  assign pending_o   = pending_cnt;
  assign broad_cnt_o = bcast_cnt;

  // Broadcast write to WR, broadcast read to RD, everything else NOP
  function automatic breq_type_t expected_type(input mbus_cmd_t cmd);
    if (cmd == MBUS_WR_BROAD) begin
      return BREQ_WR;
    end
    if (cmd == MBUS_RD_BROAD) begin
      return BREQ_RD;
    end
    return BREQ_NOP;
  endfunction

  task automatic report_mismatch(input string field, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("mismatch %0s %0s expected %h actual %h", test_name_i, field, exp, act);
    err_cnt++;
  endtask

  // ==================================================
  // Compare then advance once per clock
  // ==================================================

  // Outputs are read before the DUT registers move and belong to the ending cycle
  always @(posedge clk or posedge rst) begin : model
    int                  sel;
    int                  idx;
    logic                exp_wr;
    logic [NUM_CPUS-1:0] ack_n;
    broad_t              exp_b;
    if (rst) begin
      ack_m       = '0;
      base_m      = '0;
      prio_m      = 0;
      ack_cnt     = 0;
      bcast_cnt   = 0;
      pending_cnt = 0;
      for (int c = 0; c < NUM_CPUS; c++) begin
        type_m[c] = BREQ_NOP;
        cnt_m[c]  = 0;
      end
    end else begin
      if (mbus_ack_i !== ack_m) begin
        report_mismatch("ack", 64'(ack_m), 64'(mbus_ack_i));
      end
      for (int c = 0; c < NUM_CPUS; c++) begin
        if (mbus_ack_i[c] === 1'b1) begin
          ack_cnt++;
        end
      end
      if (broad_fifo_wr_i === 1'b1) begin
        bcast_cnt++;
      end
      // First non-empty queue upward from the priority CPU
      sel = -1;
      for (int k = 0; k < NUM_CPUS; k++) begin
        idx = (prio_m + k) % NUM_CPUS;
        if (sel < 0 && cnt_m[idx] > 0) begin
          sel = idx;
        end
      end
      exp_wr = (sel >= 0) && !broad_fifo_full_i;
      if (broad_fifo_wr_i !== exp_wr) begin
        report_mismatch("broad_fifo_wr", 64'(exp_wr), 64'(broad_fifo_wr_i));
      end
      if (exp_wr) begin
        exp_b.addr     = fifo_m[sel][0].addr;
        exp_b.req_type = fifo_m[sel][0].req_type;
        exp_b.cpu_id   = cpu_id_t'(sel);
        exp_b.id       = fifo_m[sel][0].id;
        if (broad_i !== exp_b) begin
          report_mismatch("broad", 64'(exp_b), 64'(broad_i));
        end
      end
      // Next acks use the occupancy of the ending cycle
      for (int c = 0; c < NUM_CPUS; c++) begin
        ack_n[c] = (mbus_cmd_i[c] == MBUS_WR_BROAD || mbus_cmd_i[c] == MBUS_RD_BROAD) &&
                   (cnt_m[c] < FIFO_DEPTH) && !ack_m[c];
      end
      if (exp_wr) begin
        for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
          fifo_m[sel][i] = fifo_m[sel][i + 1];
        end
        cnt_m[sel]--;
        prio_m = (prio_m + 1) % NUM_CPUS;
      end
      // Ack cycle stores live address, held type and base with slot 3 minus CPU
      for (int c = 0; c < NUM_CPUS; c++) begin
        if (ack_m[c]) begin
          fifo_m[c][cnt_m[c]].addr     = mbus_addr_i[c];
          fifo_m[c][cnt_m[c]].req_type = type_m[c];
          fifo_m[c][cnt_m[c]].id       = {base_m, 2'(3 - c)};
          cnt_m[c]++;
        end
        type_m[c] = expected_type(mbus_cmd_i[c]);
      end
      if (|ack_m) begin
        base_m = base_m + 1'b1;
      end
      ack_m       = ack_n;
      pending_cnt = ack_cnt - bcast_cnt;
    end
  end

endmodule

// File: bench/tb_breq_fifos.sv
// Testbench top for the broadcast request front end, runs the stimulus table against breq_checker
`timescale 1ns/1ps

module tb_breq_fifos;
  import breq_pkg::*;

  localparam int FIFO_DEPTH   = 2;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_ROWS     = 16;

  // One table row, commands indexed by CPU
  typedef struct packed {
    logic [127:0]             name;
    logic [NUM_CPUS-1:0][2:0] cmd;
    addr_t                    base;
    logic                     full;
    logic [15:0]              len;
  } stim_row_t;

  logic                clk;
  logic                rst;
  mbus_cmd_t           mbus_cmd [NUM_CPUS];
  addr_t               mbus_addr [NUM_CPUS];
  logic                broad_fifo_full;
  logic [NUM_CPUS-1:0] mbus_ack;
  logic                broad_fifo_wr;
  broad_t              broad;
  logic [127:0]        test_name;

  stim_row_t           table_q [MAX_ROWS];
  int                  num_rows;
  int                  total_cycles;
  logic                table_ready = 1'b0;
  // Set during the ack cycle, the CPU keeps its address until that cycle ends
  logic [NUM_CPUS-1:0] hold;
  int                  seed;
  int                  tb_errors;
  int                  chk_errors;
  int                  pending;
  int                  broad_cnt;

  breq_fifos_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk               (clk),
    .rst               (rst),
    .mbus_cmd_i        (mbus_cmd),
    .mbus_addr_i       (mbus_addr),
    .broad_fifo_full_i (broad_fifo_full),
    .mbus_ack_o        (mbus_ack),
    .broad_fifo_wr_o   (broad_fifo_wr),
    .broad_o           (broad)
  );

  breq_checker #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_checker (
    .clk               (clk),
    .rst               (rst),
    .test_name_i       (test_name),
    .mbus_cmd_i        (mbus_cmd),
    .mbus_addr_i       (mbus_addr),
    .broad_fifo_full_i (broad_fifo_full),
    .mbus_ack_i        (mbus_ack),
    .broad_fifo_wr_i   (broad_fifo_wr),
    .broad_i           (broad),
    .errors_o          (chk_errors),
    .pending_o         (pending),
    .broad_cnt_o       (broad_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==================================================
  // Stimulus table
  // ==================================================

  task automatic add_row(input logic [127:0] name, input mbus_cmd_t c0, input mbus_cmd_t c1,
                         input mbus_cmd_t c2, input mbus_cmd_t c3, input addr_t base,
                         input logic full, input int len);
    stim_row_t r;
    r.name   = name;
    r.cmd[0] = c0;
    r.cmd[1] = c1;
    r.cmd[2] = c2;
    r.cmd[3] = c3;
    r.base   = base;
    r.full   = full;
    r.len    = 16'(len);
    table_q[num_rows] = r;
    num_rows++;
    total_cycles += len;
  endtask

  task automatic build_table();
    num_rows     = 0;
    total_cycles = RESET_CYCLES;
    add_row("idle_start", MBUS_NOP, MBUS_NOP, MBUS_NOP, MBUS_NOP, 32'h0000_0000, 0, 4);
    // Lone request on an idle block, two-cycle latency
    add_row("single_cpu0", MBUS_WR_BROAD, MBUS_NOP, MBUS_NOP, MBUS_NOP, 32'h1000_0000, 0, 1);
    add_row("single_gap", MBUS_NOP, MBUS_NOP, MBUS_NOP, MBUS_NOP, 32'h0000_0000, 0, 6);
    add_row("single_cpu3", MBUS_NOP, MBUS_NOP, MBUS_NOP, MBUS_RD_BROAD, 32'h2000_0000, 0, 1);
    // Non-broadcast commands must never be acked
    add_row("plain_cmds", MBUS_WR, MBUS_RD, MBUS_EVICT, MBUS_EVICT_BROAD, 32'h3000_0000, 0, 8);
    add_row("nop_gap", MBUS_NOP, MBUS_NOP, MBUS_NOP, MBUS_NOP, 32'h0000_0000, 0, 4);
    // All four loaded, FIFOs fill and the rotation is exercised
    add_row("round_robin", MBUS_WR_BROAD, MBUS_RD_BROAD, MBUS_RD_BROAD, MBUS_WR_BROAD,
            32'h4000_0000, 0, 16);
    add_row("broad_full", MBUS_RD_BROAD, MBUS_RD_BROAD, MBUS_RD_BROAD, MBUS_RD_BROAD,
            32'h5000_0000, 1, 12);
    add_row("full_release", MBUS_NOP, MBUS_NOP, MBUS_NOP, MBUS_NOP, 32'h0000_0000, 0, 12);
    // Long single stream, base wraps past 32
    add_row("id_wrap", MBUS_NOP, MBUS_WR_BROAD, MBUS_NOP, MBUS_NOP, 32'h6000_0000, 0, 80);
    add_row("drain", MBUS_NOP, MBUS_NOP, MBUS_NOP, MBUS_NOP, 32'h0000_0000, 0, 20);
  endtask

  function automatic logic is_broadcast(input mbus_cmd_t cmd);
    return (cmd == MBUS_WR_BROAD) || (cmd == MBUS_RD_BROAD);
  endfunction

  // New command from the row, random line address inside a per-CPU window
  task automatic load_cmd(input int c, input stim_row_t row);
    mbus_cmd[c]  = mbus_cmd_t'(row.cmd[c]);
    mbus_addr[c] = row.base + (c << 12) + ({$random(seed)} & 32'h0000_0ffc);
  endtask

  task automatic report_and_finish();
    int total;
    total = tb_errors + chk_errors;
    $display("errors: %0d (checker %0d, bench %0d)", total, chk_errors, tb_errors);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  // ==================================================
  // Stimulus loop
  // ==================================================

  initial begin : stimulus
    stim_row_t row;
    seed            = 40983;
    tb_errors       = 0;
    rst             = 1'b1;
    broad_fifo_full = 1'b0;
    test_name       = "reset";
    hold            = '0;
    for (int c = 0; c < NUM_CPUS; c++) begin
      mbus_cmd[c]  = MBUS_NOP;
      mbus_addr[c] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      row             = table_q[r];
      test_name       = row.name;
      broad_fifo_full = row.full;
      for (int n = 0; n < int'(row.len); n++) begin
        // Waiting broadcasts stay put, everything else follows the row
        for (int c = 0; c < NUM_CPUS; c++) begin
          if (hold[c]) begin
            hold[c] = 1'b0;
            load_cmd(c, row);
          end else if (mbus_ack[c]) begin
            hold[c] = 1'b1;
          end else if (!is_broadcast(mbus_cmd[c])) begin
            load_cmd(c, row);
          end
        end
        @(negedge clk);
      end
    end
    if (pending != 0) begin
      $display("%0d accepted requests never reached the broadcast FIFO", pending);
      tb_errors++;
    end
    if (broad_cnt == 0) begin
      $display("no request was forwarded to the broadcast FIFO during the run");
      tb_errors++;
    end
    report_and_finish();
  end

  // Watchdog sized from the table plus slack
  initial begin : watchdog
    wait (table_ready);
    #((total_cycles + 50) * CLK_PERIOD);
    $display("run timed out after %0d cycles", total_cycles + 50);
    tb_errors++;
    report_and_finish();
  end

endmodule

// File: src.f
hdl/breq_pkg.sv
hdl/mbus_accept.sv
hdl/breq_fifo.sv
hdl/breq_arbiter.sv
hdl/breq_fifos_top.sv
bench/breq_checker.sv
bench/tb_breq_fifos.sv
